//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module tbDecodeStage -o simv
./obj_dir/simv | tee sim.log

if grep -qx "sim passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

//--- src/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    typedef enum logic [3:0] {
        ALU_ROL  = 4'd0,
        ALU_SLL  = 4'd1,
        ALU_SRL  = 4'd3,
        ALU_ADD  = 4'd4,
        ALU_XOR  = 4'd6,
        ALU_ANDN = 4'd7,
        ALU_ROR  = 4'd8
    } aluOpT;

    // second alu operand
    typedef enum logic [2:0] {
        SRC_IMM_S = 3'd0,
        SRC_IMM_Z = 3'd1,
        SRC_REG   = 3'd4,
        SRC_ZERO  = 3'd5
    } aluSrcT;

    typedef enum logic [1:0] {
        DST_I1   = 2'd0,
        DST_I2   = 2'd1,
        DST_R    = 2'd2,
        DST_LINK = 2'd3
    } regDstT;

    // writeback mux select
    typedef enum logic [2:0] {
        WB_MEM  = 3'd0,
        WB_ALU  = 3'd1,
        WB_PC   = 3'd2,
        WB_COND = 3'd3,
        WB_IMM  = 3'd4,
        WB_SLBI = 3'd5,
        WB_BTR  = 3'd6
    } wbSrcT;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQZ  = 3'd1,
        BR_NEZ  = 3'd2,
        BR_LTZ  = 3'd3,
        BR_GEZ  = 3'd4
    } brTypeT;

    typedef struct packed {
        logic   halt;
        logic   sign;
        logic   pcOffSel;
        logic   regWrt;
        logic   memWrt;
        logic   memEn;
        logic   jump;
        logic   ret;
        logic   invA;
        logic   invB;
        logic   cin;
        regDstT regDst;
        wbSrcT  regWrtSrc;
        aluOpT  aluOp;
        aluSrcT aluSrc;
        brTypeT brType;
    } ctrlWordT;

    // nop word, also the starting point of every decode
    localparam ctrlWordT CTRL_DEFAULT = '{
        halt:      1'b0,
        sign:      1'b0,
        pcOffSel:  1'b0,
        regWrt:    1'b0,
        memWrt:    1'b0,
        memEn:     1'b0,
        jump:      1'b0,
        ret:       1'b0,
        invA:      1'b0,
        invB:      1'b0,
        cin:       1'b0,
        regDst:    DST_I1,
        regWrtSrc: WB_MEM,
        aluOp:     ALU_ADD,
        aluSrc:    SRC_REG,
        brType:    BR_NONE
    };

endpackage

`default_nettype wire

//--- src/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   inValid,
    input  instrT  inInstr,
    output logic   inReady,
    output logic   outValid,
    input  logic   outReady,
    output logic   halt,
    output logic   sign,
    output logic   pcOffSel,
    output logic   regWrt,
    output logic   memWrt,
    output logic   memEn,
    output logic   jump,
    output logic   ret,
    output logic   invA,
    output logic   invB,
    output logic   cin,
    output regDstT regDst,
    output wbSrcT  regWrtSrc,
    output aluOpT  aluOp,
    output aluSrcT aluSrc,
    output brTypeT brType
);

    logic     slotValid;
    logic     slotReady;
    instrT    slotInstr;
    ctrlWordT decoded;
    ctrlWordT outWord;

    pipeSlot #(.payloadT(instrT)) inSlot (
        .clk       (clk),
        .rstN      (rstN),
        .upValid   (inValid),
        .upData    (inInstr),
        .upReady   (inReady),
        .downValid (slotValid),
        .downData  (slotInstr),
        .downReady (slotReady)
    );

    instrDecoder decoder (
        .instr (slotInstr),
        .ctrl  (decoded)
    );

    pipeSlot #(.payloadT(ctrlWordT)) outSlot (
        .clk       (clk),
        .rstN      (rstN),
        .upValid   (slotValid),
        .upData    (decoded),
        .upReady   (slotReady),
        .downValid (outValid),
        .downData  (outWord),
        .downReady (outReady)
    );

    // control word out onto the loose ports
    assign halt      = outWord.halt;
    assign sign      = outWord.sign;
    assign pcOffSel  = outWord.pcOffSel;
    assign regWrt    = outWord.regWrt;
    assign memWrt    = outWord.memWrt;
    assign memEn     = outWord.memEn;
    assign jump      = outWord.jump;
    assign ret       = outWord.ret;
    assign invA      = outWord.invA;
    assign invB      = outWord.invB;
    assign cin       = outWord.cin;
    assign regDst    = outWord.regDst;
    assign regWrtSrc = outWord.regWrtSrc;
    assign aluOp     = outWord.aluOp;
    assign aluSrc    = outWord.aluSrc;
    assign brType    = outWord.brType;

endmodule

`default_nettype wire

//--- src/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  instrT    instr,
    output ctrlWordT ctrl
);

    always_comb begin
        ctrl = CTRL_DEFAULT;
        case (instr.opCode)
            // r arithmetic, op picked by func
            ALU_OP1: begin
                ctrl.regWrt    = 1'b1;
                ctrl.regDst    = DST_R;
                ctrl.regWrtSrc = WB_ALU;
                case (instr.func)
                    FUNC_ADD: begin
                        ctrl.sign  = 1'b1;
                        ctrl.aluOp = ALU_ADD;
                    end
                    FUNC_SUB: begin
                        ctrl.sign  = 1'b1;
                        ctrl.invA  = 1'b1;
                        ctrl.cin   = 1'b1;
                        ctrl.aluOp = ALU_ADD;
                    end
                    FUNC_XOR: ctrl.aluOp = ALU_XOR;
                    FUNC_ANDN: begin
                        ctrl.invB  = 1'b1;
                        ctrl.aluOp = ALU_ANDN;
                    end
                endcase
            end
            ALU_OP2: begin
                ctrl.regWrt    = 1'b1;
                ctrl.regDst    = DST_R;
                ctrl.regWrtSrc = WB_ALU;
                case (instr.func)
                    FUNC_ROL: ctrl.aluOp = ALU_ROL;
                    FUNC_SLL: ctrl.aluOp = ALU_SLL;
                    FUNC_ROR: ctrl.aluOp = ALU_ROR;
                    FUNC_SRL: ctrl.aluOp = ALU_SRL;
                endcase
            end
            // compares subtract rs - rt
            SEQ, SLT, SLE: begin
                ctrl.regWrt    = 1'b1;
                ctrl.regDst    = DST_R;
                ctrl.regWrtSrc = WB_COND;
                ctrl.sign      = 1'b1;
                ctrl.invB      = 1'b1;
                ctrl.cin       = 1'b1;
                ctrl.aluOp     = ALU_ADD;
            end
            SCO: begin
                ctrl.regWrt    = 1'b1;
                ctrl.regDst    = DST_R;
                ctrl.regWrtSrc = WB_COND;
                ctrl.aluOp     = ALU_ADD;
            end
            BTR: begin
                ctrl.regWrt    = 1'b1;
                ctrl.regDst    = DST_R;
                ctrl.regWrtSrc = WB_BTR;
            end
            ADDI, SUBI, XORI, ANDNI, ROLI, SLLI, RORI, SRLI: begin
                ctrl.regWrt    = 1'b1;
                ctrl.regDst    = DST_I1;
                ctrl.regWrtSrc = WB_ALU;
                ctrl.aluSrc    = SRC_IMM_Z;
                case (instr.opCode)
                    ADDI: begin
                        ctrl.sign   = 1'b1;
                        ctrl.aluSrc = SRC_IMM_S;
                        ctrl.aluOp  = ALU_ADD;
                    end
                    SUBI: begin
                        ctrl.sign   = 1'b1;
                        ctrl.invA   = 1'b1;
                        ctrl.cin    = 1'b1;
                        ctrl.aluSrc = SRC_IMM_S;
                        ctrl.aluOp  = ALU_ADD;
                    end
                    XORI:  ctrl.aluOp = ALU_XOR;
                    ANDNI: begin
                        ctrl.invB  = 1'b1;
                        ctrl.aluOp = ALU_ANDN;
                    end
                    ROLI:    ctrl.aluOp = ALU_ROL;
                    SLLI:    ctrl.aluOp = ALU_SLL;
                    RORI:    ctrl.aluOp = ALU_ROR;
                    default: ctrl.aluOp = ALU_SRL;
                endcase
            end
            ST: begin
                ctrl.memWrt = 1'b1;
                ctrl.memEn  = 1'b1;
                ctrl.aluSrc = SRC_IMM_S;
                ctrl.aluOp  = ALU_ADD;
            end
            LD: begin
                ctrl.regWrt    = 1'b1;
                ctrl.regDst    = DST_I1;
                ctrl.regWrtSrc = WB_MEM;
                ctrl.memEn     = 1'b1;
                ctrl.aluSrc    = SRC_IMM_S;
                ctrl.aluOp     = ALU_ADD;
            end
            // store with base update, new address goes back to rs
            STU: begin
                ctrl.regWrt    = 1'b1;
                ctrl.regDst    = DST_I2;
                ctrl.regWrtSrc = WB_ALU;
                ctrl.memWrt    = 1'b1;
                ctrl.memEn     = 1'b1;
                ctrl.sign      = 1'b1;
                ctrl.aluSrc    = SRC_IMM_S;
                ctrl.aluOp     = ALU_ADD;
            end
            LBI, SLBI: begin
                ctrl.regWrt    = 1'b1;
                ctrl.regDst    = DST_I2;
                ctrl.regWrtSrc = (instr.opCode == LBI) ? WB_IMM : WB_SLBI;
            end
            JR, JALR, J, JAL: begin
                ctrl.jump     = 1'b1;
                ctrl.ret      = (instr.opCode == JR) || (instr.opCode == JALR);
                ctrl.pcOffSel = (instr.opCode == J) || (instr.opCode == JAL);
                if (instr.opCode == JALR || instr.opCode == JAL) begin
                    ctrl.regWrt    = 1'b1;
                    ctrl.regDst    = DST_LINK;
                    ctrl.regWrtSrc = WB_PC;
                end
            end
            // branch tests rs against zero through the alu
            BEQZ, BNEZ, BLTZ, BGEZ: begin
                ctrl.sign   = 1'b1;
                ctrl.aluSrc = SRC_ZERO;
                ctrl.aluOp  = ALU_ADD;
                case (instr.opCode)
                    BEQZ:    ctrl.brType = BR_EQZ;
                    BNEZ:    ctrl.brType = BR_NEZ;
                    BLTZ:    ctrl.brType = BR_LTZ;
                    default: ctrl.brType = BR_GEZ;
                endcase
            end
            HALT: ctrl.halt = 1'b1;
            NOP, SIIC, RTI: ctrl = CTRL_DEFAULT;
        endcase
    end

    always_comb begin
        memWrtNeedsEn: assert (!ctrl.memWrt || ctrl.memEn)
            else $error("instrDecoder: memWrt without memEn");
        haltIsQuiet: assert (!ctrl.halt || (!ctrl.regWrt && !ctrl.memWrt))
            else $error("instrDecoder: halt with a write enabled");
    end

endmodule

`default_nettype wire

//--- src/isaPkg.sv
`default_nettype none

package isaPkg;

    typedef logic [4:0] opCodeT;
    typedef logic [1:0] funcT;

    typedef struct packed {
        opCodeT opCode;
        funcT   func;
    } instrT;

    // i1 format
    localparam opCodeT ADDI    = 5'b01000;
    localparam opCodeT SUBI    = 5'b01001;
    localparam opCodeT XORI    = 5'b01010;
    localparam opCodeT ANDNI   = 5'b01011;
    localparam opCodeT ROLI    = 5'b10100;
    localparam opCodeT SLLI    = 5'b10101;
    localparam opCodeT RORI    = 5'b10110;
    localparam opCodeT SRLI    = 5'b10111;
    localparam opCodeT ST      = 5'b10000;
    localparam opCodeT LD      = 5'b10001;
    localparam opCodeT STU     = 5'b10011;

    // r format
    localparam opCodeT BTR     = 5'b11001;
    localparam opCodeT ALU_OP1 = 5'b11011;
    localparam opCodeT ALU_OP2 = 5'b11010;
    localparam opCodeT SEQ     = 5'b11100;
    localparam opCodeT SLT     = 5'b11101;
    localparam opCodeT SLE     = 5'b11110;
    localparam opCodeT SCO     = 5'b11111;

    // i2 format
    localparam opCodeT LBI     = 5'b11000;
    localparam opCodeT SLBI    = 5'b10010;
    localparam opCodeT JR      = 5'b00101;
    localparam opCodeT JALR    = 5'b00111;
    localparam opCodeT BEQZ    = 5'b01100;
    localparam opCodeT BNEZ    = 5'b01101;
    localparam opCodeT BLTZ    = 5'b01110;
    localparam opCodeT BGEZ    = 5'b01111;

    // j format and specials
    localparam opCodeT J       = 5'b00100;
    localparam opCodeT JAL     = 5'b00110;
    localparam opCodeT SIIC    = 5'b00010;
    localparam opCodeT RTI     = 5'b00011;
    localparam opCodeT HALT    = 5'b00000;
    localparam opCodeT NOP     = 5'b00001;

    // func field of ALU_OP1
    localparam funcT FUNC_ADD  = 2'h0;
    localparam funcT FUNC_SUB  = 2'h1;
    localparam funcT FUNC_XOR  = 2'h2;
    localparam funcT FUNC_ANDN = 2'h3;

    // func field of ALU_OP2
    localparam funcT FUNC_ROL  = 2'h0;
    localparam funcT FUNC_SLL  = 2'h1;
    localparam funcT FUNC_ROR  = 2'h2;
    localparam funcT FUNC_SRL  = 2'h3;

endpackage

`default_nettype wire

//--- src/pipeSlot.sv
`timescale 1ns/1ps
`default_nettype none

module pipeSlot #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    upValid,
    input  payloadT upData,
    output logic    upReady,
    output logic    downValid,
    output payloadT downData,
    input  logic    downReady
);

    logic    full;
    payloadT data;

    // take a new item when empty or when the held one leaves this cycle
    assign upReady   = !full || downReady;
    assign downValid = full;
    assign downData  = data;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            full <= 1'b0;
        end else if (upValid && upReady) begin
            full <= 1'b1;
        end else if (downReady) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (upValid && upReady) begin
            data <= upData;
        end
    end

    // stalled output must hold until taken
    holdWhileStalled: assert property (
        @(posedge clk) disable iff (!rstN)
        downValid && !downReady |=> downValid && $stable(downData)
    ) else $error("pipeSlot: output changed while stalled");

endmodule

`default_nettype wire

//--- tb.f
src/isaPkg.sv
src/ctrlPkg.sv
src/pipeSlot.sv
src/instrDecoder.sv
src/decodeStage.sv
verif/tbDecodeStage.sv

//--- verif/decodeCases.txt
// columns: opcode, func, expected control word (all hex)
// word bits: halt sign pcOffSel regWrt memWrt memEn jump ret invA invB cin regDst wbSrc aluOp aluSrc brType
00 0 2000120
01 3 0000120
02 0 0000120
03 1 0000120
04 0 0880120
05 0 00c0120
06 0 0c86920
07 0 04c6920
08 0 1400500
09 0 1428500
0a 0 0400588
0b 0 04105c8
0c 0 1000129
0d 0 100012a
0e 0 100012b
0f 0 100012c
10 0 0300100
11 0 0500100
12 0 0403520
13 0 1702500
14 0 0400408
15 0 0400448
16 0 0400608
17 0 04004c8
18 0 0403120
19 0 0405920
1a 0 0404420
1a 1 0404460
1a 2 0404620
1a 3 04044e0
1b 0 1404520
1b 1 142c520
1b 2 04045a0
1b 3 04145e0
1c 0 141cd20
1d 0 141cd20
1e 0 141cd20
1f 0 0404d20
00 2 2000120

//--- verif/tbDecodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module tbDecodeStage
    import isaPkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_CASES       = 39;
    localparam int NUM_PASSES      = 3;
    localparam int STALL_CYCLES    = 5;
    localparam int WATCHDOG_CYCLES = NUM_CASES * NUM_PASSES * 8 + 100;
    localparam int WORD_W          = 26;

    logic        clk = 1'b0;
    logic        rstN;
    logic        inValid;
    instrT       inInstr;
    logic        inReady;
    logic        outValid;
    logic        outReady;
    logic        halt;
    logic        sign;
    logic        pcOffSel;
    logic        regWrt;
    logic        memWrt;
    logic        memEn;
    logic        jump;
    logic        ret;
    logic        invA;
    logic        invB;
    logic        cin;
    logic [1:0]  regDst;
    logic [2:0]  regWrtSrc;
    logic [3:0]  aluOp;
    logic [2:0]  aluSrc;
    logic [2:0]  brType;

    // three entries per case for opcode, func and expected word
    logic [WORD_W-1:0] caseMem [0:3*NUM_CASES-1];
    logic [WORD_W-1:0] expQ [$];
    logic [WORD_W-1:0] heldWord;
    logic              heldValid;
    logic              backToBack;
    int                recvCount;
    int                passBase;
    int                haltSeen;
    int                mismatches;
    int                otherErrors;

    decodeStage u_decodeStage (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inInstr   (inInstr),
        .inReady   (inReady),
        .outValid  (outValid),
        .outReady  (outReady),
        .halt      (halt),
        .sign      (sign),
        .pcOffSel  (pcOffSel),
        .regWrt    (regWrt),
        .memWrt    (memWrt),
        .memEn     (memEn),
        .jump      (jump),
        .ret       (ret),
        .invA      (invA),
        .invB      (invB),
        .cin       (cin),
        .regDst    (regDst),
        .regWrtSrc (regWrtSrc),
        .aluOp     (aluOp),
        .aluSrc    (aluSrc),
        .brType    (brType)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [WORD_W-1:0] actual,
                              input logic [WORD_W-1:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t",
                     name, actual, expected, $time);
            mismatches++;
        end
    endtask

    function automatic logic [WORD_W-1:0] outWordNow();
        return {halt, sign, pcOffSel, regWrt, memWrt, memEn, jump, ret, invA, invB, cin,
                regDst, regWrtSrc, aluOp, aluSrc, brType};
    endfunction

    function automatic instrT instrOf(input int idx);
        return {caseMem[3 * idx][4:0], caseMem[3 * idx + 1][1:0]};
    endfunction

    // field positions follow the control word layout with halt at the top
    task automatic checkOutput(input logic [WORD_W-1:0] exp);
        checkValue("halt", WORD_W'(halt), WORD_W'(exp[25]));
        checkValue("sign", WORD_W'(sign), WORD_W'(exp[24]));
        checkValue("pcOffSel", WORD_W'(pcOffSel), WORD_W'(exp[23]));
        checkValue("regWrt", WORD_W'(regWrt), WORD_W'(exp[22]));
        checkValue("memWrt", WORD_W'(memWrt), WORD_W'(exp[21]));
        checkValue("memEn", WORD_W'(memEn), WORD_W'(exp[20]));
        checkValue("jump", WORD_W'(jump), WORD_W'(exp[19]));
        checkValue("ret", WORD_W'(ret), WORD_W'(exp[18]));
        checkValue("invA", WORD_W'(invA), WORD_W'(exp[17]));
        checkValue("invB", WORD_W'(invB), WORD_W'(exp[16]));
        checkValue("cin", WORD_W'(cin), WORD_W'(exp[15]));
        checkValue("regDst", WORD_W'(regDst), WORD_W'(exp[14:13]));
        checkValue("regWrtSrc", WORD_W'(regWrtSrc), WORD_W'(exp[12:10]));
        checkValue("aluOp", WORD_W'(aluOp), WORD_W'(exp[9:6]));
        checkValue("aluSrc", WORD_W'(aluSrc), WORD_W'(exp[5:3]));
        checkValue("brType", WORD_W'(brType), WORD_W'(exp[2:0]));
    endtask

    task automatic nextCycle(input bit randomMode);
        @(negedge clk);
        if (randomMode) begin
            outReady = ($urandom_range(0, 3) != 0);
        end
    endtask

    // present one case and hold it until the DUT takes it
    task automatic sendCase(input int idx, input bit randomMode, output int stalls);
        stalls = 0;
        if (randomMode) begin
            while ($urandom_range(0, 2) == 0) begin
                inValid = 1'b0;
                nextCycle(randomMode);
            end
        end
        inValid = 1'b1;
        inInstr = instrOf(idx);
        @(posedge clk);
        while (!inReady) begin
            stalls++;
            nextCycle(randomMode);
            @(posedge clk);
        end
        expQ.push_back(caseMem[3 * idx + 2]);
        nextCycle(randomMode);
    endtask

    task automatic waitDrained(input int target);
        while (recvCount < target) begin
            @(negedge clk);
        end
    endtask

    task automatic stallPass();
        int stalls;
        outReady = 1'b0;
        sendCase(0, 1'b0, stalls);
        // one item held with room for another
        checkValue("inReady", WORD_W'(inReady), WORD_W'(1'b1));
        sendCase(1, 1'b0, stalls);
        inValid = 1'b1;
        inInstr = instrOf(2);
        repeat (STALL_CYCLES) begin
            checkValue("inReady", WORD_W'(inReady), WORD_W'(1'b0));
            @(negedge clk);
        end
        outReady = 1'b1;
        for (int i = 2; i < NUM_CASES; i++) begin
            sendCase(i, 1'b0, stalls);
            checkValue("input stalls", WORD_W'(stalls), '0);
        end
        inValid = 1'b0;
    endtask

    // scoreboard, hold check and stream gaps on the output side
    always @(posedge clk) begin
        if (!rstN) begin
            heldValid = 1'b0;
        end else begin
            if (heldValid) begin
                checkValue("outValid", WORD_W'(outValid), WORD_W'(1'b1));
                checkValue("control word", outWordNow(), heldWord);
            end
            if (backToBack && recvCount > passBase && recvCount < passBase + NUM_CASES
                    && !(outValid && outReady)) begin
                $display("ERROR: gap in the output stream after %0d results",
                         recvCount - passBase);
                otherErrors++;
            end
            if (outValid && outReady) begin
                if (expQ.size() == 0) begin
                    $display("ERROR: result left the DUT with no instruction outstanding");
                    otherErrors++;
                end else begin
                    checkOutput(expQ.pop_front());
                end
                if (halt) begin
                    haltSeen++;
                end
                recvCount++;
            end
            heldValid = outValid && !outReady;
            heldWord  = outWordNow();
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the run did not finish",
                 WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin
        int stalls;
        int haltCases;
        void'($urandom(32'h915f_eb4a));
        mismatches  = 0;
        otherErrors = 0;
        recvCount   = 0;
        passBase    = 0;
        haltSeen    = 0;
        haltCases   = 0;
        backToBack  = 1'b0;
        rstN        = 1'b0;
        inValid     = 1'b0;
        inInstr     = '0;
        outReady    = 1'b0;
        $readmemh("verif/decodeCases.txt", caseMem);
        for (int i = 0; i < NUM_CASES; i++) begin
            if (caseMem[3 * i][4:0] == HALT) begin
                haltCases++;
            end
        end

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checkValue("outValid", WORD_W'(outValid), WORD_W'(1'b0));
        end
        rstN = 1'b1;
        @(negedge clk);
        checkValue("outValid", WORD_W'(outValid), WORD_W'(1'b0));
        checkValue("inReady", WORD_W'(inReady), WORD_W'(1'b1));

        // full rate stream
        outReady   = 1'b1;
        backToBack = 1'b1;
        passBase   = recvCount;
        for (int i = 0; i < NUM_CASES; i++) begin
            sendCase(i, 1'b0, stalls);
            checkValue("input stalls", WORD_W'(stalls), '0);
        end
        inValid = 1'b0;
        waitDrained(passBase + NUM_CASES);
        backToBack = 1'b0;

        // random input gaps and random output ready
        passBase = recvCount;
        for (int i = 0; i < NUM_CASES; i++) begin
            sendCase(i, 1'b1, stalls);
        end
        inValid  = 1'b0;
        outReady = 1'b1;
        waitDrained(passBase + NUM_CASES);

        passBase = recvCount;
        stallPass();
        waitDrained(passBase + NUM_CASES);

        repeat (4) @(negedge clk);
        if (expQ.size() != 0) begin
            $display("ERROR: %0d results never left the DUT", expQ.size());
            otherErrors++;
        end
        if (haltSeen != NUM_PASSES * haltCases) begin
            $display("ERROR: halt was set on %0d results instead of %0d",
                     haltSeen, NUM_PASSES * haltCases);
            otherErrors++;
        end
        $display("errors: %0d value mismatches, %0d other failures", mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
